// ==== bench/conv_slice_asserts.sv ====
// Output protocol assertions for the conversion slice, bound to its top level
module conv_slice_asserts (
  input logic                              clk_i,
  input logic                              rst_n_i,
  input logic                              flush_i,
  input logic                              out_ready_i,
  input logic                              out_valid_i,
  input logic                              busy_i,
  input conv_slice_pkg::slice_word_u       result_i,
  input conv_slice_pkg::status_t           status_i,
  input logic [conv_slice_pkg::TAG_W-1:0]  tag_i
);

  int unsigned fail_count = 0;  // Read by the testbench at the end of the run

  // A stalled beat keeps its value until it is taken
  stall_hold_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out_valid_i && !out_ready_i && !flush_i |=>
      out_valid_i && $stable(result_i) && $stable(status_i) && $stable(tag_i))
    else begin
      $error("stalled output changed or was dropped");
      fail_count++;
    end

  flush_clear_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    flush_i |=> !out_valid_i)
    else begin
      $error("output valid right after a flush");
      fail_count++;
    end

  reset_idle_a: assert property (@(posedge clk_i) !rst_n_i |=> !out_valid_i && !busy_i)
    else begin
      $error("output valid or busy during reset");
      fail_count++;
    end

endmodule

bind conv_slice_top conv_slice_asserts i_asserts (
  .clk_i,
  .rst_n_i,
  .flush_i,
  .out_ready_i,
  .out_valid_i ( out_valid_o ),
  .busy_i      ( busy_o      ),
  .result_i    ( result_o    ),
  .status_i    ( status_o    ),
  .tag_i       ( tag_o       )
);

// ==== bench/tb_conv_slice.sv ====
// Testbench for the FP16/FP8 conversion slice with a vector table and scoreboard
module tb_conv_slice;
  import conv_slice_pkg::*;

  typedef struct {
    conv_op_e    op;
    fp_fmt_e     fmt;
    logic        md;
    logic        vec;
    roundmode_e  rm;
    logic [1:0]  mask;
    slice_word_u a, b, c;
    slice_word_u res;
    status_t     st;
  } vec_entry_t;

  localparam status_t ST_NONE = 5'b00000;
  localparam status_t ST_NX   = 5'b00001;
  localparam status_t ST_UFNX = 5'b00011;
  localparam status_t ST_OFNX = 5'b00101;
  localparam status_t ST_NV   = 5'b10000;

  logic                 clk, rst_n;
  slice_word_u          op_a, op_b, op_c, result;
  conv_op_e             op;
  logic                 op_mod, vectorial, in_valid, flush, out_ready;
  fp_fmt_e              dst_fmt;
  roundmode_e           rnd_mode;
  logic [TAG_W-1:0]     tag, tag_out;
  logic [NUM_LANES-1:0] simd_mask;
  status_t              status;
  logic                 out_valid, in_ready, busy;

  vec_entry_t  table_q[$];
  int unsigned sb_idx_q[$];    // Table index of each accepted beat
  int unsigned sb_cycle_q[$];  // Cycle of acceptance
  int unsigned cycle;
  int unsigned num_checked = 0;
  int          ready_mode = 0; // 0 always ready, 1 random stalls, 2 held low

  conv_slice_top i_dut (
    .clk_i       ( clk       ),
    .rst_n_i     ( rst_n     ),
    .op_a_i      ( op_a      ),
    .op_b_i      ( op_b      ),
    .op_c_i      ( op_c      ),
    .op_i        ( op        ),
    .op_mod_i    ( op_mod    ),
    .dst_fmt_i   ( dst_fmt   ),
    .rnd_mode_i  ( rnd_mode  ),
    .tag_i       ( tag       ),
    .simd_mask_i ( simd_mask ),
    .vectorial_i ( vectorial ),
    .in_valid_i  ( in_valid  ),
    .flush_i     ( flush     ),
    .out_ready_i ( out_ready ),
    .result_o    ( result    ),
    .status_o    ( status    ),
    .tag_o       ( tag_out   ),
    .out_valid_o ( out_valid ),
    .in_ready_o  ( in_ready  ),
    .busy_o      ( busy      )
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Output side ready and cycle count, both updated on the falling edge
  initial begin
    void'($urandom(79));
    out_ready = 1'b0;
    cycle     = 0;
    forever begin
      @(negedge clk);
      cycle++;
      case (ready_mode)
        0:       out_ready = 1'b1;
        1:       out_ready = ($urandom_range(3) != 0);  // About one stall in four
        default: out_ready = 1'b0;
      endcase
    end
  end

  // ------------------------------------------------------------
  // Reporting and compare tasks
  // ------------------------------------------------------------
  task automatic stop_run(input string line);
    $display("%s", line);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_word(input slice_word_u got, input slice_word_u exp, input string what);
    if (got !== exp) begin
      stop_run($sformatf("[ERROR] %0t: %s result %08h, expected %08h", $time, what, got, exp));
    end
  endtask

  task automatic check_status(input status_t got, input status_t exp, input string what);
    if (got !== exp) begin
      stop_run($sformatf("[ERROR] %0t: %s status %05b, expected %05b", $time, what, got, exp));
    end
  endtask

  task automatic check_tag(input logic [TAG_W-1:0] got, input logic [TAG_W-1:0] exp,
                           input string what);
    if (got !== exp) begin
      stop_run($sformatf("[ERROR] %0t: %s tag %0h, expected %0h", $time, what, got, exp));
    end
  endtask

  task automatic check_latency(input int unsigned got, input string what);
    if (got != NUM_PIPE_REGS) begin
      stop_run($sformatf("[ERROR] %0t: %s latency %0d cycles, expected %0d",
                         $time, what, got, NUM_PIPE_REGS));
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      stop_run($sformatf("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp));
    end
  endtask

  // ------------------------------------------------------------
  // Stimulus table and driver
  // ------------------------------------------------------------
  task automatic add_entry(input conv_op_e op_e, input fp_fmt_e fmt, input logic md,
                           input logic vec, input roundmode_e rm, input logic [1:0] mask,
                           input logic [31:0] a, input logic [31:0] b, input logic [31:0] c,
                           input logic [31:0] res, input status_t st);
    vec_entry_t e;
    e = '{op: op_e, fmt: fmt, md: md, vec: vec, rm: rm, mask: mask,
          a: a, b: b, c: c, res: res, st: st};
    table_q.push_back(e);
  endtask

  task automatic build_table();
    // Scalar up casts FP8 to FP16
    add_entry(OP_F2F, FMT_FP16, 0, 0, RNE, 2'b11, 32'h0000_003C, 0, 0, 32'hFFFF_3C00, ST_NONE);
    add_entry(OP_F2F, FMT_FP16, 0, 0, RNE, 2'b11, 32'h0000_007D, 0, 0, 32'hFFFF_7E00, ST_NV);
    add_entry(OP_F2F, FMT_FP16, 0, 0, RTZ, 2'b11, 32'h0000_007E, 0, 0, 32'hFFFF_7E00, ST_NONE);
    // Scalar down casts, ties and directed rounding
    add_entry(OP_F2F, FMT_FP8, 0, 0, RNE, 2'b11, 32'h0000_3C80, 0, 0, 32'hFFFF_FF3C, ST_NX);
    add_entry(OP_F2F, FMT_FP8, 0, 0, RTZ, 2'b11, 32'h0000_3C80, 0, 0, 32'hFFFF_FF3C, ST_NX);
    add_entry(OP_F2F, FMT_FP8, 0, 0, RUP, 2'b11, 32'h0000_3C80, 0, 0, 32'hFFFF_FF3D, ST_NX);
    add_entry(OP_F2F, FMT_FP8, 0, 0, RDN, 2'b11, 32'h0000_3C80, 0, 0, 32'hFFFF_FF3C, ST_NX);
    add_entry(OP_F2F, FMT_FP8, 0, 0, RNE, 2'b11, 32'h0000_3D80, 0, 0, 32'hFFFF_FF3E, ST_NX);
    add_entry(OP_F2F, FMT_FP8, 0, 0, RTZ, 2'b11, 32'h0000_3D80, 0, 0, 32'hFFFF_FF3D, ST_NX);
    add_entry(OP_F2F, FMT_FP8, 0, 0, RDN, 2'b11, 32'h0000_BC80, 0, 0, 32'hFFFF_FFBD, ST_NX);
    add_entry(OP_F2F, FMT_FP8, 0, 0, RUP, 2'b11, 32'h0000_BC80, 0, 0, 32'hFFFF_FFBC, ST_NX);
    add_entry(OP_F2F, FMT_FP8, 0, 0, RNE, 2'b11, 32'h0000_3C00, 0, 0, 32'hFFFF_FF3C, ST_NONE);
    // Overflow at the top of the range
    add_entry(OP_F2F, FMT_FP8, 0, 0, RNE, 2'b11, 32'h0000_7BFF, 0, 0, 32'hFFFF_FF7C, ST_OFNX);
    add_entry(OP_F2F, FMT_FP8, 0, 0, RTZ, 2'b11, 32'h0000_7BFF, 0, 0, 32'hFFFF_FF7B, ST_NX);
    add_entry(OP_F2F, FMT_FP8, 0, 0, RUP, 2'b11, 32'h0000_7BFF, 0, 0, 32'hFFFF_FF7C, ST_OFNX);
    add_entry(OP_F2F, FMT_FP8, 0, 0, RDN, 2'b11, 32'h0000_7BFF, 0, 0, 32'hFFFF_FF7B, ST_NX);
    add_entry(OP_F2F, FMT_FP8, 0, 0, RDN, 2'b11, 32'h0000_FBFF, 0, 0, 32'hFFFF_FFFC, ST_OFNX);
    // Subnormal, NaN and infinity inputs
    add_entry(OP_F2F, FMT_FP8, 0, 0, RNE, 2'b11, 32'h0000_0001, 0, 0, 32'hFFFF_FF00, ST_UFNX);
    add_entry(OP_F2F, FMT_FP8, 0, 0, RUP, 2'b11, 32'h0000_0001, 0, 0, 32'hFFFF_FF01, ST_UFNX);
    add_entry(OP_F2F, FMT_FP8, 0, 0, RNE, 2'b11, 32'h0000_7D00, 0, 0, 32'hFFFF_FF7E, ST_NV);
    add_entry(OP_F2F, FMT_FP8, 0, 0, RNE, 2'b11, 32'h0000_7E00, 0, 0, 32'hFFFF_FF7E, ST_NONE);
    add_entry(OP_F2F, FMT_FP8, 0, 0, RTZ, 2'b11, 32'h0000_7C00, 0, 0, 32'hFFFF_FF7C, ST_NONE);
    // Vectorial casts
    add_entry(OP_F2F, FMT_FP16, 0, 1, RNE, 2'b11, 32'h4438_C03C, 0, 0, 32'hC000_3C00, ST_NONE);
    add_entry(OP_F2F, FMT_FP16, 1, 1, RNE, 2'b11, 32'h4438_C03C, 0, 0, 32'h4400_3800, ST_NONE);
    add_entry(OP_F2F, FMT_FP8, 0, 1, RNE, 2'b11, 32'h3D80_3C80, 0, 0, 32'hFFFF_3E3C, ST_NX);
    // Cast-and-pack into operand C, dst_fmt is ignored
    add_entry(OP_CPKAB, FMT_FP16, 0, 0, RNE, 2'b11, 32'hABCD_3C00, 32'h1357_C400,
              32'h1122_3344, 32'h1122_C43C, ST_NONE);
    add_entry(OP_CPKCD, FMT_FP8, 0, 0, RNE, 2'b11, 32'hABCD_3C80, 32'h1357_C400,
              32'h1122_3344, 32'hC43C_3344, ST_NX);
    // Only lane 1 overflows, its flags depend on its mask bit
    add_entry(OP_F2F, FMT_FP8, 0, 1, RNE, 2'b11, 32'h7BFF_3C00, 0, 0, 32'hFFFF_7C3C, ST_OFNX);
    add_entry(OP_F2F, FMT_FP8, 0, 1, RNE, 2'b01, 32'h7BFF_3C00, 0, 0, 32'hFFFF_7C3C, ST_NONE);
    add_entry(OP_F2F, FMT_FP8, 0, 1, RNE, 2'b10, 32'h7BFF_3C00, 0, 0, 32'hFFFF_7C3C, ST_OFNX);
  endtask

  task automatic send_entry(input int unsigned idx);
    vec_entry_t  e;
    int unsigned waited;
    e = table_q[idx];
    @(negedge clk);
    op        = e.op;
    dst_fmt   = e.fmt;
    op_mod    = e.md;
    vectorial = e.vec;
    rnd_mode  = e.rm;
    simd_mask = e.mask;
    op_a      = e.a;
    op_b      = e.b;
    op_c      = e.c;
    tag       = idx[TAG_W-1:0];
    in_valid  = 1'b1;
    waited    = 0;
    @(posedge clk);
    while (!in_ready) begin  // Ready seen before the edge updates the pipeline
      waited++;
      if (waited > 50) begin
        stop_run($sformatf("entry %0d was never accepted by the slice", idx));
      end
      @(posedge clk);
    end
    sb_idx_q.push_back(idx);
    sb_cycle_q.push_back(cycle);
  endtask

  task automatic wait_drain();
    int unsigned waited;
    waited = 0;
    while (sb_idx_q.size() != 0) begin
      waited++;
      if (waited > 200) begin
        stop_run("results still missing long after the last input");
      end
      @(negedge clk);
    end
  endtask

  task automatic run_table();
    for (int unsigned i = 0; i < table_q.size(); i++) begin
      send_entry(i);
    end
    @(negedge clk);
    in_valid = 1'b0;
    wait_drain();
  endtask

  task automatic set_ready_mode(input int mode);
    @(posedge clk);
    ready_mode = mode;
  endtask

  // ------------------------------------------------------------
  // Output scoreboard
  // ------------------------------------------------------------
  task automatic score_beat();
    int unsigned idx;
    int unsigned acc_cycle;
    string       what;
    if (sb_idx_q.size() == 0) begin
      stop_run("the slice gave an output with no item in flight");
    end else begin
      idx       = sb_idx_q.pop_front();
      acc_cycle = sb_cycle_q.pop_front();
      what      = $sformatf("entry %0d", idx);
      check_word(result, table_q[idx].res, what);
      check_status(status, table_q[idx].st, what);
      check_tag(tag_out, idx[TAG_W-1:0], what);
      if (ready_mode == 0) begin
        check_latency(cycle - acc_cycle, what);
      end
      num_checked++;
    end
  endtask

  always @(posedge clk) begin
    if (rst_n && out_valid && out_ready) begin
      score_beat();
    end
  end

  initial begin
    rst_n     = 1'b0;
    op_a      = '0;
    op_b      = '0;
    op_c      = '0;
    op        = OP_F2F;
    op_mod    = 1'b0;
    dst_fmt   = FMT_FP16;
    rnd_mode  = RNE;
    tag       = '0;
    simd_mask = '0;
    vectorial = 1'b0;
    in_valid  = 1'b0;
    flush     = 1'b0;
    build_table();
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
    check_bit(out_valid, 1'b0, "out_valid after reset");
    check_bit(busy, 1'b0, "busy after reset");
    check_bit(in_ready, 1'b1, "in_ready after reset");

    run_table();          // Back to back with the output always ready
    set_ready_mode(1);
    run_table();          // Same table under random output stalls
    set_ready_mode(2);

    // Two items held in the pipe, then flushed
    send_entry(0);
    send_entry(1);
    @(negedge clk);
    in_valid = 1'b0;
    flush    = 1'b1;
    check_bit(busy, 1'b1, "busy with items in flight");
    @(negedge clk);
    flush = 1'b0;
    check_bit(busy, 1'b0, "busy after flush");
    sb_idx_q.delete();
    sb_cycle_q.delete();
    set_ready_mode(0);
    repeat (4) begin
      @(negedge clk);
      check_bit(out_valid, 1'b0, "out_valid after flush");
    end

    if (num_checked == 2 * table_q.size() && i_dut.i_asserts.fail_count == 0) begin
      $display("Simulation passed");
      $finish;
    end else begin
      stop_run($sformatf("%0d of %0d results checked, %0d assertion failures", num_checked,
                         2 * table_q.size(), i_dut.i_asserts.fail_count));
    end
  end

endmodule

// ==== rtl/cast_lane.sv ====
// One FP16/FP8 cast lane with its elastic valid/ready pipeline
module cast_lane (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  logic [15:0]                       src_i,
  input  logic                              up_cast_i,
  input  conv_slice_pkg::roundmode_e        rnd_mode_i,
  input  logic [conv_slice_pkg::AUX_W-1:0]  aux_i,
  input  logic [conv_slice_pkg::TAG_W-1:0]  tag_i,
  input  logic                              mask_i,
  input  logic                              in_valid_i,
  input  logic                              flush_i,
  input  logic                              out_ready_i,
  output logic                              in_ready_o,
  output logic [15:0]                       result_o,
  output conv_slice_pkg::status_t           status_o,
  output logic [conv_slice_pkg::AUX_W-1:0]  aux_o,
  output logic [conv_slice_pkg::TAG_W-1:0]  tag_o,
  output logic                              mask_o,
  output logic                              out_valid_o,
  output logic                              busy_o
);
  import conv_slice_pkg::*;

  localparam int unsigned PAY_W = 16 + $bits(status_t) + AUX_W + TAG_W + 1;

  logic [15:0] src16;     // Source seen in FP16 layout
  logic        sign;
  logic [4:0]  exp_f;
  logic [9:0]  man_f;
  logic        is_nan, is_inf, is_snan;
  logic        round_bit, sticky, inexact;
  logic        round_up;
  logic [6:0]  rounded;   // Exponent and 2-bit mantissa after rounding
  logic [15:0] cast_res;
  status_t     cast_stat;

  // ----------------------------------------------------------
  // Cast datapath
  // ----------------------------------------------------------
  // An FP8 value is an FP16 value with a short mantissa since exponent and bias match
  assign src16   = up_cast_i ? {src_i[7:0], 8'h00} : src_i;
  assign sign    = src16[15];
  assign exp_f   = src16[14:10];
  assign man_f   = src16[9:0];
  assign is_nan  = (&exp_f) & (|man_f);
  assign is_inf  = (&exp_f) & ~(|man_f);
  assign is_snan = is_nan & ~man_f[9];

  assign round_bit = man_f[7];
  assign sticky    = |man_f[6:0];
  assign inexact   = round_bit | sticky;

  always_comb begin
    case (rnd_mode_i)
      RNE:     round_up = round_bit & (sticky | man_f[8]);  // Ties to even
      RDN:     round_up = inexact & sign;
      RUP:     round_up = inexact & ~sign;
      default: round_up = 1'b0;
    endcase
  end

  // Carry ripples into the exponent so subnormals need no special path
  assign rounded = {exp_f, man_f[9:8]} + 7'(round_up);

  always_comb begin
    cast_stat = '0;
    if (is_nan) begin
      cast_res     = up_cast_i ? CANON_NAN16 : {8'hFF, CANON_NAN8};
      cast_stat.nv = is_snan;
    end else if (up_cast_i) begin
      cast_res = src16;                      // Exact widening
    end else if (is_inf) begin
      cast_res = {8'hFF, sign, 7'h7C};
    end else if (&rounded[6:2]) begin
      // Only a round away from zero carries past the largest finite value
      cast_res     = {8'hFF, sign, 7'h7C};
      cast_stat.of = 1'b1;
      cast_stat.nx = 1'b1;
    end else begin
      cast_res     = {8'hFF, sign, rounded};
      cast_stat.uf = ~(|rounded[6:2]) & inexact;
      cast_stat.nx = inexact;
    end
  end

  // ----------------------------------------------------------
  // Elastic pipeline where index i holds the item after i stages
  // ----------------------------------------------------------
  logic [0:NUM_PIPE_REGS]            valid_q;
  logic [0:NUM_PIPE_REGS]            stage_ready;
  logic [0:NUM_PIPE_REGS][PAY_W-1:0] pay_q;

  assign valid_q[0] = in_valid_i;
  assign pay_q[0]   = {cast_res, cast_stat, aux_i, tag_i, mask_i};

  for (genvar i = 0; i < NUM_PIPE_REGS; i++) begin : gen_stage
    // Advance when the next stage moves on or holds a bubble
    assign stage_ready[i] = stage_ready[i+1] | ~valid_q[i+1];

    always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
        valid_q[i+1] <= 1'b0;
      end else if (flush_i) begin
        valid_q[i+1] <= 1'b0;
      end else if (stage_ready[i]) begin
        valid_q[i+1] <= valid_q[i];
      end
    end

    always_ff @(posedge clk_i) begin
      if (stage_ready[i] && valid_q[i]) begin
        pay_q[i+1] <= pay_q[i];
      end
    end
  end

  assign stage_ready[NUM_PIPE_REGS] = out_ready_i;

  assign in_ready_o  = stage_ready[0];
  assign out_valid_o = valid_q[NUM_PIPE_REGS];
  assign busy_o      = |valid_q[1:NUM_PIPE_REGS];
  assign {result_o, status_o, aux_o, tag_o, mask_o} = pay_q[NUM_PIPE_REGS];

endmodule

// ==== rtl/conv_slice_pkg.sv ====
// Shared types and constants of the FP16/FP8 conversion slice
package conv_slice_pkg;

  // ----------------------------------------------------------
  // Slice geometry
  // ----------------------------------------------------------
  localparam int unsigned WIDTH         = 32;
  localparam int unsigned NUM_LANES     = 2;
  localparam int unsigned NUM_PIPE_REGS = 2;  // Stages per lane and in the bypass
  localparam int unsigned TAG_W         = 4;
  localparam int unsigned AUX_W         = 3;  // Vector flag, result format, cpk flag
  localparam int unsigned BYP_CTL_W     = 2;  // Cpk flag, byte pair select

  // ----------------------------------------------------------
  // Encodings
  // ----------------------------------------------------------
  typedef enum logic {
    FMT_FP16 = 1'b0,
    FMT_FP8  = 1'b1   // e5m2, same exponent and bias as FP16
  } fp_fmt_e;

  typedef enum logic [1:0] {
    OP_F2F   = 2'd0,
    OP_CPKAB = 2'd1,  // Pack into bytes 1:0 of operand C
    OP_CPKCD = 2'd2   // Pack into bytes 3:2 of operand C
  } conv_op_e;

  typedef enum logic [1:0] {
    RNE = 2'd0,
    RTZ = 2'd1,
    RDN = 2'd2,
    RUP = 2'd3
  } roundmode_e;

  // Exception flags in the usual order
  typedef struct packed {
    logic nv;
    logic dz;  // Never raised by a cast
    logic of;
    logic uf;
    logic nx;
  } status_t;

  // One data word seen as FP16 halves or as FP8 bytes
  typedef union packed {
    logic [1:0][15:0] fp16;
    logic [3:0][7:0]  fp8;
  } slice_word_u;

  localparam logic [15:0] CANON_NAN16 = 16'h7E00;
  localparam logic [7:0]  CANON_NAN8  = 8'h7E;

endpackage

// ==== rtl/conv_slice_top.sv ====
// FP16/FP8 conversion slice top level with two SIMD cast lanes
module conv_slice_top (
  input  logic                                  clk_i,
  input  logic                                  rst_n_i,
  input  conv_slice_pkg::slice_word_u           op_a_i,
  input  conv_slice_pkg::slice_word_u           op_b_i,
  input  conv_slice_pkg::slice_word_u           op_c_i,
  input  conv_slice_pkg::conv_op_e              op_i,
  input  logic                                  op_mod_i,
  input  conv_slice_pkg::fp_fmt_e               dst_fmt_i,
  input  conv_slice_pkg::roundmode_e            rnd_mode_i,
  input  logic [conv_slice_pkg::TAG_W-1:0]      tag_i,
  input  logic [conv_slice_pkg::NUM_LANES-1:0]  simd_mask_i,
  input  logic                                  vectorial_i,
  input  logic                                  in_valid_i,
  input  logic                                  flush_i,
  input  logic                                  out_ready_i,
  output conv_slice_pkg::slice_word_u           result_o,
  output conv_slice_pkg::status_t               status_o,
  output logic [conv_slice_pkg::TAG_W-1:0]      tag_o,
  output logic                                  out_valid_o,
  output logic                                  in_ready_o,
  output logic                                  busy_o
);
  import conv_slice_pkg::*;

  logic [NUM_LANES-1:0][15:0] lane_src, lane_result;
  status_t [NUM_LANES-1:0]    lane_status;
  logic [NUM_LANES-1:0]       lane_in_valid, lane_in_ready, lane_out_valid, lane_out_ready;
  logic [NUM_LANES-1:0]       lane_mask, lane_valid, lane_busy;
  logic                       is_cpk, up_cast, vec_op, byp_valid;
  logic [AUX_W-1:0]           aux, res_aux;
  logic [WIDTH-1:0]           byp_target;
  logic [BYP_CTL_W-1:0]       byp_ctl;
  fp_fmt_e                    res_fmt;
  logic                       res_is_cpk, res_vec_op;

  assign out_valid_o = lane_out_valid[0];

  slice_ctrl i_ctrl (
    .op_i,
    .dst_fmt_i,
    .vectorial_i,
    .in_valid_i,
    .out_ready_i,
    .lane_in_ready_i  ( lane_in_ready  ),
    .lane_out_valid_i ( lane_out_valid ),
    .lane_busy_i      ( lane_busy      ),
    .res_aux_i        ( res_aux        ),
    .byp_aux_i        ( byp_ctl        ),
    .lane_in_valid_o  ( lane_in_valid  ),
    .lane_out_ready_o ( lane_out_ready ),
    .lane_valid_o     ( lane_valid     ),
    .in_ready_o,
    .busy_o,
    .is_cpk_o         ( is_cpk         ),
    .up_cast_o        ( up_cast        ),
    .vec_op_o         ( vec_op         ),
    .aux_o            ( aux            ),
    .byp_valid_o      ( byp_valid      ),
    .res_is_vector_o  (                ),
    .res_fmt_o        ( res_fmt        ),
    .res_is_cpk_o     ( res_is_cpk     ),
    .res_vec_op_o     ( res_vec_op     )
  );

  lane_operand_select i_opsel (
    .op_a_i,
    .op_b_i,
    .dst_fmt_i,
    .is_cpk_i   ( is_cpk   ),
    .up_cast_i  ( up_cast  ),
    .op_mod_i,
    .lane_src_o ( lane_src )
  );

  // Lane 0 carries the tag and the result control
  cast_lane i_lane0 (
    .clk_i,
    .rst_n_i,
    .src_i       ( lane_src[0]       ),
    .up_cast_i   ( up_cast           ),
    .rnd_mode_i,
    .aux_i       ( aux               ),
    .tag_i,
    .mask_i      ( simd_mask_i[0]    ),
    .in_valid_i  ( lane_in_valid[0]  ),
    .flush_i,
    .out_ready_i ( lane_out_ready[0] ),
    .in_ready_o  ( lane_in_ready[0]  ),
    .result_o    ( lane_result[0]    ),
    .status_o    ( lane_status[0]    ),
    .aux_o       ( res_aux           ),
    .tag_o,
    .mask_o      ( lane_mask[0]      ),
    .out_valid_o ( lane_out_valid[0] ),
    .busy_o      ( lane_busy[0]      )
  );

  cast_lane i_lane1 (
    .clk_i,
    .rst_n_i,
    .src_i       ( lane_src[1]       ),
    .up_cast_i   ( up_cast           ),
    .rnd_mode_i,
    .aux_i       ( aux               ),
    .tag_i,
    .mask_i      ( simd_mask_i[1]    ),
    .in_valid_i  ( lane_in_valid[1]  ),
    .flush_i,
    .out_ready_i ( lane_out_ready[1] ),
    .in_ready_o  ( lane_in_ready[1]  ),
    .result_o    ( lane_result[1]    ),
    .status_o    ( lane_status[1]    ),
    .aux_o       (                   ),
    .tag_o       (                   ),
    .mask_o      ( lane_mask[1]      ),
    .out_valid_o ( lane_out_valid[1] ),
    .busy_o      ( lane_busy[1]      )
  );

  cpk_bypass_pipe i_bypass (
    .clk_i,
    .rst_n_i,
    .target_i ( op_c_i            ),
    .ctl_i    ( {is_cpk, vec_op}  ),
    .valid_i  ( byp_valid         ),
    .flush_i,
    .ready_i  ( lane_out_ready[1] ),
    .target_o ( byp_target        ),
    .ctl_o    ( byp_ctl           )
  );

  result_pack i_pack (
    .lane_result_i ( lane_result ),
    .lane_status_i ( lane_status ),
    .lane_mask_i   ( lane_mask   ),
    .lane_valid_i  ( lane_valid  ),
    .res_fmt_i     ( res_fmt     ),
    .res_is_cpk_i  ( res_is_cpk  ),
    .res_vec_op_i  ( res_vec_op  ),
    .target_i      ( byp_target  ),
    .result_o,
    .status_o
  );

endmodule

// ==== rtl/cpk_bypass_pipe.sv ====
// Bypass pipeline carrying operand C and pack control beside the cast lanes
module cpk_bypass_pipe (
  input  logic                                  clk_i,
  input  logic                                  rst_n_i,
  input  logic [conv_slice_pkg::WIDTH-1:0]      target_i,
  input  logic [conv_slice_pkg::BYP_CTL_W-1:0]  ctl_i,
  input  logic                                  valid_i,
  input  logic                                  flush_i,
  input  logic                                  ready_i,
  output logic [conv_slice_pkg::WIDTH-1:0]      target_o,
  output logic [conv_slice_pkg::BYP_CTL_W-1:0]  ctl_o
);
  import conv_slice_pkg::*;

  localparam int unsigned PAY_W = WIDTH + BYP_CTL_W;

  logic [0:NUM_PIPE_REGS]            valid_q;
  logic [0:NUM_PIPE_REGS]            stage_ready;
  logic [0:NUM_PIPE_REGS][PAY_W-1:0] pay_q;

  assign valid_q[0] = valid_i;
  assign pay_q[0]   = {ctl_i, target_i};

  // Same depth and advance rule as a lane, so it stays aligned with lane 1
  for (genvar i = 0; i < NUM_PIPE_REGS; i++) begin : gen_stage
    assign stage_ready[i] = stage_ready[i+1] | ~valid_q[i+1];

    always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
        valid_q[i+1] <= 1'b0;
      end else if (flush_i) begin
        valid_q[i+1] <= 1'b0;
      end else if (stage_ready[i]) begin
        valid_q[i+1] <= valid_q[i];
      end
    end

    always_ff @(posedge clk_i) begin
      if (stage_ready[i] && valid_q[i]) begin
        pay_q[i+1] <= pay_q[i];
      end
    end
  end

  assign stage_ready[NUM_PIPE_REGS] = ready_i;

  assign {ctl_o, target_o} = pay_q[NUM_PIPE_REGS];

endmodule

// ==== rtl/lane_operand_select.sv ====
// Per-lane cast source selection from operands A and B
module lane_operand_select (
  input  conv_slice_pkg::slice_word_u                 op_a_i,
  input  conv_slice_pkg::slice_word_u                 op_b_i,
  input  conv_slice_pkg::fp_fmt_e                     dst_fmt_i,
  input  logic                                        is_cpk_i,
  input  logic                                        up_cast_i,
  input  logic                                        op_mod_i,
  output logic [conv_slice_pkg::NUM_LANES-1:0][15:0]  lane_src_o
);
  import conv_slice_pkg::*;

  logic fp8_src;

  // FP8 operands only feed an F2F up cast into FP16
  assign fp8_src = up_cast_i & (dst_fmt_i == FMT_FP16);

  always_comb begin
    for (int n = 0; n < NUM_LANES; n++) begin
      if (is_cpk_i) begin
        // Cast-and-pack takes the low half of A and of B
        lane_src_o[n] = (n == 0) ? op_a_i.fp16[0] : op_b_i.fp16[0];
      end else if (fp8_src) begin
        lane_src_o[n] = {8'h00, op_a_i.fp8[op_mod_i ? n + 2 : n]};  // op_mod picks bytes 3:2
      end else begin
        lane_src_o[n] = op_a_i.fp16[n];
      end
    end
  end

endmodule

// ==== rtl/result_pack.sv ====
// Result assembly: per-format packing, NaN-boxing, cast-and-pack and status collapse
module result_pack (
  input  logic [conv_slice_pkg::NUM_LANES-1:0][15:0]  lane_result_i,
  input  conv_slice_pkg::status_t [conv_slice_pkg::NUM_LANES-1:0] lane_status_i,
  input  logic [conv_slice_pkg::NUM_LANES-1:0]        lane_mask_i,
  input  logic [conv_slice_pkg::NUM_LANES-1:0]        lane_valid_i,
  input  conv_slice_pkg::fp_fmt_e                     res_fmt_i,
  input  logic                                        res_is_cpk_i,
  input  logic                                        res_vec_op_i,
  input  logic [conv_slice_pkg::WIDTH-1:0]            target_i,
  output conv_slice_pkg::slice_word_u                 result_o,
  output conv_slice_pkg::status_t                     status_o
);
  import conv_slice_pkg::*;

  slice_word_u lane_word;  // Lanes packed in their format, boxed with ones
  slice_word_u cpk_word;
  status_t     stat;

  // ----------------------------------------------------------
  // Data
  // ----------------------------------------------------------
  always_comb begin
    lane_word = '1;
    for (int n = 0; n < NUM_LANES; n++) begin
      if (lane_valid_i[n]) begin
        if (res_fmt_i == FMT_FP16) begin
          lane_word.fp16[n] = lane_result_i[n];
        end else begin
          lane_word.fp8[n] = lane_result_i[n][7:0];  // Bytes 3:2 stay boxed
        end
      end
    end

    // Two FP8 bytes overwrite one byte pair of C
    cpk_word                   = target_i;
    cpk_word.fp16[res_vec_op_i] = lane_word.fp16[0];

    result_o = res_is_cpk_i ? cpk_word : lane_word;
  end

  // ----------------------------------------------------------
  // Status, only active and unmasked lanes contribute
  // ----------------------------------------------------------
  always_comb begin
    stat = '0;
    for (int n = 0; n < NUM_LANES; n++) begin
      if (lane_valid_i[n] && lane_mask_i[n]) begin
        stat = stat | lane_status_i[n];
      end
    end
    status_o = stat;
  end

endmodule

// ==== rtl/slice_ctrl.sv ====
// Conversion slice control: op decode, lane handshake gating and result decode
module slice_ctrl (
  input  conv_slice_pkg::conv_op_e                 op_i,
  input  conv_slice_pkg::fp_fmt_e                  dst_fmt_i,
  input  logic                                     vectorial_i,
  input  logic                                     in_valid_i,
  input  logic                                     out_ready_i,
  input  logic [conv_slice_pkg::NUM_LANES-1:0]     lane_in_ready_i,
  input  logic [conv_slice_pkg::NUM_LANES-1:0]     lane_out_valid_i,
  input  logic [conv_slice_pkg::NUM_LANES-1:0]     lane_busy_i,
  input  logic [conv_slice_pkg::AUX_W-1:0]         res_aux_i,
  input  logic [conv_slice_pkg::BYP_CTL_W-1:0]     byp_aux_i,
  output logic [conv_slice_pkg::NUM_LANES-1:0]     lane_in_valid_o,
  output logic [conv_slice_pkg::NUM_LANES-1:0]     lane_out_ready_o,
  output logic [conv_slice_pkg::NUM_LANES-1:0]     lane_valid_o,
  output logic                                     in_ready_o,
  output logic                                     busy_o,
  output logic                                     is_cpk_o,
  output logic                                     up_cast_o,
  output logic                                     vec_op_o,
  output logic [conv_slice_pkg::AUX_W-1:0]         aux_o,
  output logic                                     byp_valid_o,
  output logic                                     res_is_vector_o,
  output conv_slice_pkg::fp_fmt_e                  res_fmt_o,
  output logic                                     res_is_cpk_o,
  output logic                                     res_vec_op_o
);
  import conv_slice_pkg::*;

  logic    need_hi;  // Lane 1 and the bypass take part
  fp_fmt_e lane_fmt;

  // ----------------------------------------------------------
  // Input side
  // ----------------------------------------------------------
  assign is_cpk_o  = (op_i == OP_CPKAB) || (op_i == OP_CPKCD);
  assign vec_op_o  = (op_i == OP_CPKCD);                       // Upper byte pair of C
  assign up_cast_o = !is_cpk_o && (dst_fmt_i == FMT_FP16);     // Source is FP8
  assign need_hi   = vectorial_i | is_cpk_o;
  assign lane_fmt  = is_cpk_o ? FMT_FP8 : dst_fmt_i;
  assign aux_o     = {need_hi, lane_fmt, is_cpk_o};

  // Upper lane must have room too when it is needed
  assign in_ready_o = lane_in_ready_i[0] & (lane_in_ready_i[1] | ~need_hi);

  assign lane_in_valid_o[0] = in_valid_i & in_ready_o;
  assign lane_in_valid_o[1] = in_valid_i & in_ready_o & need_hi;
  assign byp_valid_o        = lane_in_valid_o[1];  // Bypass moves with lane 1

  // ----------------------------------------------------------
  // Output side, decoded from the item held in lane 0
  // ----------------------------------------------------------
  assign res_is_vector_o = res_aux_i[2];
  assign res_fmt_o       = fp_fmt_e'(res_aux_i[1]);
  assign res_is_cpk_o    = res_aux_i[0];
  assign res_vec_op_o    = byp_aux_i[1] & byp_aux_i[0];  // Pair select only for packs

  assign lane_out_ready_o[0] = out_ready_i;
  assign lane_out_ready_o[1] = out_ready_i & res_is_vector_o;

  // Lane 1 may already hold the next vector item behind a scalar
  assign lane_valid_o[0] = lane_out_valid_i[0];
  assign lane_valid_o[1] = lane_out_valid_i[1] & res_is_vector_o;

  assign busy_o = |lane_busy_i;

endmodule

// ==== src.f ====
rtl/conv_slice_pkg.sv
rtl/slice_ctrl.sv
rtl/lane_operand_select.sv
rtl/cast_lane.sv
rtl/cpk_bypass_pipe.sv
rtl/result_pack.sv
rtl/conv_slice_top.sv
bench/conv_slice_asserts.sv
bench/tb_conv_slice.sv
